// File: rtl/mipsPkg.sv
package mipsPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam logic [DataWidth-1:0] ResetPc = 32'h0000_0000;

	// Primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'd0,
		opJ       = 6'd2,
		opBeq     = 6'd4,
		opBne     = 6'd5,
		opAddi    = 6'd8,
		opAddiu   = 6'd9,
		opSlti    = 6'd10,
		opSltiu   = 6'd11,
		opAndi    = 6'd12,
		opOri     = 6'd13,
		opXori    = 6'd14,
		opLui     = 6'd15,
		opLw      = 6'd35,
		opSw      = 6'd43
	} opcodeE;

	// Function field of SPECIAL, inst[5:0]
	typedef enum logic [5:0] {
		fnSll   = 6'd0,
		fnAdd   = 6'd32,
		fnAddu  = 6'd33,
		fnSub   = 6'd34,
		fnSubu  = 6'd35,
		fnAndOp = 6'd36,
		fnOrOp  = 6'd37,
		fnXorOp = 6'd38,
		fnNorOp = 6'd39,
		fnSlt   = 6'd42,
		fnSltu  = 6'd43
	} functE;

	typedef enum logic [3:0] {
		aluAnd  = 4'd0,
		aluOr   = 4'd1,
		aluAdd  = 4'd2,
		aluNor  = 4'd3,
		aluXor  = 4'd4,
		aluSub  = 4'd6,
		aluSlt  = 4'd7,
		aluSll  = 4'd10,
		aluLui  = 4'd11,
		aluSltu = 4'd14
	} aluOpE;

	typedef enum logic [1:0] {bReg, bImm, bShamt} aluBSrcE;
	typedef enum logic {wbAlu, wbMem} wbSrcE;
	typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelE;

endpackage

// File: rtl/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit (
	input  logic Clk,
	input  logic rstN,
	input  logic redirect,
	input  logic [mipsPkg::DataWidth-1:0] redirectTarget,
	input  logic flush,
	input  logic [mipsPkg::DataWidth-1:0] imemData,
	output logic [mipsPkg::DataWidth-1:0] imemAddr,
	output logic [mipsPkg::DataWidth-1:0] instId,
	output logic [mipsPkg::DataWidth-1:0] pcId
);

	logic [mipsPkg::DataWidth-1:0] pc;

	always_ff @(posedge Clk) begin
		if (!rstN)
			pc <= mipsPkg::ResetPc;
		else if (redirect)
			pc <= redirectTarget; // Branch or jump
		else
			pc <= pc + mipsPkg::DataWidth'(4);
	end

	assign imemAddr = pc;

	// Flushed slot becomes a zero word, which decodes as NOP
	always_ff @(posedge Clk) begin
		if (!rstN || flush)
			instId <= '0;
		else
			instId <= imemData;
	end

	always_ff @(posedge Clk) begin
		pcId <= pc;
	end

	// Targets come from decode and execute
	pcAligned: assert property (@(posedge Clk) disable iff (!rstN)
		pc[1:0] == 2'b00);

endmodule

// File: rtl/instDecoder.sv
`timescale 1ns/10ps

module instDecoder (
	input  logic [mipsPkg::DataWidth-1:0] inst,
	output mipsPkg::aluOpE aluOp,
	output mipsPkg::aluBSrcE aluBSrc,
	output logic signExtend,
	output logic regWrite,
	output logic dstIsRd,
	output logic memWrite,
	output mipsPkg::wbSrcE wbSrc,
	output logic branchEq,
	output logic branchNe,
	output logic jump
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = inst[31:26];
	assign funct = inst[5:0];

	always_comb begin
		aluOp = mipsPkg::aluAnd;
		aluBSrc = mipsPkg::bReg;
		signExtend = 1'b0;
		regWrite = 1'b0;
		dstIsRd = 1'b0;
		memWrite = 1'b0;
		wbSrc = mipsPkg::wbAlu;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		if (inst != '0) begin
			case (opcode)
				mipsPkg::opSpecial: begin
					regWrite = 1'b1;
					dstIsRd = 1'b1;
					case (funct)
						mipsPkg::fnSll: begin
							aluOp = mipsPkg::aluSll;
							aluBSrc = mipsPkg::bShamt;
						end
						mipsPkg::fnAdd, mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
						mipsPkg::fnSub, mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
						mipsPkg::fnAndOp: aluOp = mipsPkg::aluAnd;
						mipsPkg::fnOrOp: aluOp = mipsPkg::aluOr;
						mipsPkg::fnXorOp: aluOp = mipsPkg::aluXor;
						mipsPkg::fnNorOp: aluOp = mipsPkg::aluNor;
						mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
						mipsPkg::fnSltu: aluOp = mipsPkg::aluSltu;
						default: begin
							regWrite = 1'b0; // Unsupported function
							dstIsRd = 1'b0;
						end
					endcase
				end
				mipsPkg::opAddi, mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu,
				mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
					regWrite = 1'b1;
					aluBSrc = mipsPkg::bImm;
					case (opcode)
						mipsPkg::opSlti: aluOp = mipsPkg::aluSlt;
						mipsPkg::opSltiu: aluOp = mipsPkg::aluSltu;
						mipsPkg::opAndi: aluOp = mipsPkg::aluAnd;
						mipsPkg::opOri: aluOp = mipsPkg::aluOr;
						mipsPkg::opXori: aluOp = mipsPkg::aluXor;
						mipsPkg::opLui: aluOp = mipsPkg::aluLui;
						default: aluOp = mipsPkg::aluAdd;
					endcase
					// Logical immediates are zero extended
					signExtend = !(opcode inside {mipsPkg::opAndi, mipsPkg::opOri,
						mipsPkg::opXori, mipsPkg::opLui});
				end
				mipsPkg::opLw: begin
					aluOp = mipsPkg::aluAdd;
					aluBSrc = mipsPkg::bImm;
					signExtend = 1'b1;
					regWrite = 1'b1;
					wbSrc = mipsPkg::wbMem;
				end
				mipsPkg::opSw: begin
					aluOp = mipsPkg::aluAdd;
					aluBSrc = mipsPkg::bImm;
					signExtend = 1'b1;
					memWrite = 1'b1;
				end
				mipsPkg::opBeq, mipsPkg::opBne: begin
					aluOp = mipsPkg::aluSub;
					signExtend = 1'b1; // Branch offset
					branchEq = (opcode == mipsPkg::opBeq);
					branchNe = (opcode == mipsPkg::opBne);
				end
				mipsPkg::opJ: jump = 1'b1;
				default: ; // Anything else is a NOP
			endcase
		end
	end

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/10ps

module registerFile (
	input  logic Clk,
	input  logic rstN,
	input  logic [mipsPkg::RegAddrWidth-1:0] rdAddrA,
	input  logic [mipsPkg::RegAddrWidth-1:0] rdAddrB,
	input  logic [mipsPkg::RegAddrWidth-1:0] wrAddr,
	input  logic [mipsPkg::DataWidth-1:0] wrData,
	input  logic wrEn,
	output logic [mipsPkg::DataWidth-1:0] rdDataA,
	output logic [mipsPkg::DataWidth-1:0] rdDataB
);

	logic [mipsPkg::DataWidth-1:0] regs [2**mipsPkg::RegAddrWidth];
	logic wrValid;

	assign wrValid = wrEn && (wrAddr != '0); // $zero is never written

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			for (int i = 0; i < 2**mipsPkg::RegAddrWidth; i++)
				regs[i] <= '0;
		end else if (wrValid) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Writeback in the same cycle as decode reads
	assign rdDataA = (wrValid && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrValid && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// File: rtl/forwardingUnit.sv
`timescale 1ns/10ps

module forwardingUnit (
	input  logic [mipsPkg::RegAddrWidth-1:0] rsEx,
	input  logic [mipsPkg::RegAddrWidth-1:0] rtEx,
	input  logic [mipsPkg::RegAddrWidth-1:0] wrAddrMem,
	input  logic regWriteMem,
	input  logic [mipsPkg::RegAddrWidth-1:0] wrAddrWb,
	input  logic regWriteWb,
	output mipsPkg::fwdSelE fwdA,
	output mipsPkg::fwdSelE fwdB
);

	// Newest producer wins
	function automatic mipsPkg::fwdSelE pickSource(input logic [mipsPkg::RegAddrWidth-1:0] src);
		if (src == '0)
			return mipsPkg::fwdReg;
		else if (regWriteMem && wrAddrMem == src)
			return mipsPkg::fwdMem;
		else if (regWriteWb && wrAddrWb == src)
			return mipsPkg::fwdWb;
		else
			return mipsPkg::fwdReg;
	endfunction

	always_comb begin
		fwdA = pickSource(rsEx);
		fwdB = pickSource(rtEx);
	end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/10ps

module executeStage (
	input  mipsPkg::aluOpE aluOp,
	input  mipsPkg::aluBSrcE aluBSrc,
	input  logic [mipsPkg::DataWidth-1:0] rsData,
	input  logic [mipsPkg::DataWidth-1:0] rtData,
	input  logic [mipsPkg::DataWidth-1:0] memResult,
	input  logic [mipsPkg::DataWidth-1:0] wbResult,
	input  mipsPkg::fwdSelE fwdA,
	input  mipsPkg::fwdSelE fwdB,
	input  logic [mipsPkg::DataWidth-1:0] imm,
	input  logic [4:0] shamt,
	input  logic [mipsPkg::DataWidth-1:0] pcEx,
	input  logic branchEq,
	input  logic branchNe,
	output logic [mipsPkg::DataWidth-1:0] aluResult,
	output logic [mipsPkg::DataWidth-1:0] storeData,
	output logic branchTaken,
	output logic [mipsPkg::DataWidth-1:0] branchTarget
);

	logic [mipsPkg::DataWidth-1:0] opA;
	logic [mipsPkg::DataWidth-1:0] rtFwd;
	logic [mipsPkg::DataWidth-1:0] opB;
	logic operandsEqual;

	function automatic logic [mipsPkg::DataWidth-1:0] pickOperand(
		input mipsPkg::fwdSelE sel,
		input logic [mipsPkg::DataWidth-1:0] regVal,
		input logic [mipsPkg::DataWidth-1:0] memVal,
		input logic [mipsPkg::DataWidth-1:0] wbVal
	);
		case (sel)
			mipsPkg::fwdMem: return memVal;
			mipsPkg::fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, rsData, memResult, wbResult);
	assign rtFwd = pickOperand(fwdB, rtData, memResult, wbResult);
	assign storeData = rtFwd; // SW data

	always_comb begin
		case (aluBSrc)
			mipsPkg::bImm: opB = imm;
			mipsPkg::bShamt: opB = {{(mipsPkg::DataWidth-5){1'b0}}, shamt};
			default: opB = rtFwd;
		endcase
	end

	always_comb begin
		case (aluOp)
			mipsPkg::aluAnd: aluResult = opA & opB;
			mipsPkg::aluOr: aluResult = opA | opB;
			mipsPkg::aluAdd: aluResult = opA + opB;
			mipsPkg::aluNor: aluResult = ~(opA | opB);
			mipsPkg::aluXor: aluResult = opA ^ opB;
			mipsPkg::aluSub: aluResult = opA - opB;
			mipsPkg::aluSlt:
				aluResult = {{(mipsPkg::DataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
			mipsPkg::aluSltu:
				aluResult = {{(mipsPkg::DataWidth-1){1'b0}}, opA < opB};
			mipsPkg::aluSll: aluResult = rtFwd << opB[4:0]; // SLL shifts rt, not rs
			mipsPkg::aluLui: aluResult = {opB[15:0], 16'h0000};
			default: aluResult = '0;
		endcase
	end

	// Compare on forwarded values so a result one ahead is seen
	assign operandsEqual = (opA == rtFwd);
	assign branchTaken = (branchEq && operandsEqual) || (branchNe && !operandsEqual);
	assign branchTarget = pcEx + mipsPkg::DataWidth'(4) + (imm << 2);

endmodule

// File: rtl/mipsCore.sv
`timescale 1ns/10ps

module mipsCore (
	input  logic Clk,
	input  logic rstN,
	input  logic [mipsPkg::DataWidth-1:0] imemData,
	input  logic [mipsPkg::DataWidth-1:0] dmemRdData,
	output logic [mipsPkg::DataWidth-1:0] imemAddr,
	output logic [mipsPkg::DataWidth-1:0] dmemAddr,
	output logic [mipsPkg::DataWidth-1:0] dmemWrData,
	output logic dmemWrEn
);

	logic [mipsPkg::DataWidth-1:0] instId, pcId, rsDataId, rtDataId, immId;
	logic [mipsPkg::DataWidth-1:0] jumpTarget, redirectTarget;
	logic [mipsPkg::RegAddrWidth-1:0] wrAddrId;
	mipsPkg::aluOpE aluOpId, aluOpEx;
	mipsPkg::aluBSrcE aluBSrcId, aluBSrcEx;
	mipsPkg::wbSrcE wbSrcId, wbSrcEx, wbSrcMem, wbSrcWb;
	logic signExtendId, dstIsRdId, jumpId;
	logic regWriteId, regWriteEx, regWriteMem, regWriteWb;
	logic memWriteId, memWriteEx, memWriteMem;
	logic branchEqId, branchEqEx, branchNeId, branchNeEx;
	logic redirect, flush;

	logic [mipsPkg::DataWidth-1:0] rsDataEx, rtDataEx, immEx, pcEx;
	logic [mipsPkg::DataWidth-1:0] aluResultEx, storeDataEx, branchTarget;
	logic [4:0] shamtEx;
	logic [mipsPkg::RegAddrWidth-1:0] rsEx, rtEx, wrAddrEx;
	mipsPkg::fwdSelE fwdA, fwdB;
	logic branchTaken;

	logic [mipsPkg::DataWidth-1:0] aluResultMem, storeDataMem, memResult;
	logic [mipsPkg::RegAddrWidth-1:0] wrAddrMem;
	logic [mipsPkg::DataWidth-1:0] aluResultWb, memDataWb, wbResult;
	logic [mipsPkg::RegAddrWidth-1:0] wrAddrWb;

	// Older branch beats a jump sitting in decode
	assign redirect = branchTaken || jumpId;
	assign redirectTarget = branchTaken ? branchTarget : jumpTarget;
	assign flush = redirect;

	fetchUnit fetch (.Clk, .rstN, .redirect, .redirectTarget, .flush, .imemData,
		.imemAddr, .instId, .pcId);

	instDecoder decoder (.inst(instId), .aluOp(aluOpId), .aluBSrc(aluBSrcId),
		.signExtend(signExtendId), .regWrite(regWriteId), .dstIsRd(dstIsRdId),
		.memWrite(memWriteId), .wbSrc(wbSrcId), .branchEq(branchEqId),
		.branchNe(branchNeId), .jump(jumpId));

	registerFile regFile (.Clk, .rstN, .rdAddrA(instId[25:21]), .rdAddrB(instId[20:16]),
		.wrAddr(wrAddrWb), .wrData(wbResult), .wrEn(regWriteWb),
		.rdDataA(rsDataId), .rdDataB(rtDataId));

	assign immId = signExtendId ? {{16{instId[15]}}, instId[15:0]} : {16'h0000, instId[15:0]};
	assign wrAddrId = dstIsRdId ? instId[15:11] : instId[20:16];
	assign jumpTarget = {pcId[31:28] + 4'(&pcId[27:2]), instId[25:0], 2'b00}; // Region of pc+4

	always_ff @(posedge Clk) begin
		if (!rstN || branchTaken) begin
			regWriteEx <= 1'b0;
			memWriteEx <= 1'b0;
			branchEqEx <= 1'b0;
			branchNeEx <= 1'b0;
			aluOpEx <= mipsPkg::aluAnd;
			aluBSrcEx <= mipsPkg::bReg;
			wbSrcEx <= mipsPkg::wbAlu;
		end else begin
			regWriteEx <= regWriteId;
			memWriteEx <= memWriteId;
			branchEqEx <= branchEqId;
			branchNeEx <= branchNeId;
			aluOpEx <= aluOpId;
			aluBSrcEx <= aluBSrcId;
			wbSrcEx <= wbSrcId;
		end
	end

	always_ff @(posedge Clk) begin
		rsDataEx <= rsDataId;
		rtDataEx <= rtDataId;
		immEx <= immId;
		shamtEx <= instId[10:6];
		pcEx <= pcId;
		rsEx <= instId[25:21];
		rtEx <= instId[20:16];
		wrAddrEx <= wrAddrId;
	end

	forwardingUnit fwdUnit (.rsEx, .rtEx, .wrAddrMem, .regWriteMem, .wrAddrWb, .regWriteWb,
		.fwdA, .fwdB);

	executeStage execute (.aluOp(aluOpEx), .aluBSrc(aluBSrcEx), .rsData(rsDataEx),
		.rtData(rtDataEx), .memResult, .wbResult, .fwdA, .fwdB, .imm(immEx),
		.shamt(shamtEx), .pcEx, .branchEq(branchEqEx), .branchNe(branchNeEx),
		.aluResult(aluResultEx), .storeData(storeDataEx), .branchTaken, .branchTarget);

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			regWriteMem <= 1'b0;
			memWriteMem <= 1'b0;
			wbSrcMem <= mipsPkg::wbAlu;
			regWriteWb <= 1'b0;
			wbSrcWb <= mipsPkg::wbAlu;
		end else begin
			regWriteMem <= regWriteEx;
			memWriteMem <= memWriteEx;
			wbSrcMem <= wbSrcEx;
			regWriteWb <= regWriteMem;
			wbSrcWb <= wbSrcMem;
		end
	end

	always_ff @(posedge Clk) begin
		aluResultMem <= aluResultEx;
		storeDataMem <= storeDataEx;
		wrAddrMem <= wrAddrEx;
		aluResultWb <= aluResultMem;
		memDataWb <= dmemRdData;
		wrAddrWb <= wrAddrMem;
	end

	assign dmemAddr = aluResultMem;
	assign dmemWrData = storeDataMem;
	assign dmemWrEn = memWriteMem;

	// Load data is forwarded straight from the memory stage
	assign memResult = (wbSrcMem == mipsPkg::wbMem) ? dmemRdData : aluResultMem;
	assign wbResult = (wbSrcWb == mipsPkg::wbMem) ? memDataWb : aluResultWb;

	aluOpValid: assert property (@(posedge Clk) disable iff (!rstN)
		regWriteEx |-> !$isunknown(aluOpEx) && aluOpEx inside {mipsPkg::aluAnd,
		mipsPkg::aluOr, mipsPkg::aluAdd, mipsPkg::aluNor, mipsPkg::aluXor, mipsPkg::aluSub,
		mipsPkg::aluSlt, mipsPkg::aluSltu, mipsPkg::aluSll, mipsPkg::aluLui});

endmodule

// File: dv/tbClock.sv
`timescale 1ns/10ps

module tbClock (
	output logic Clk
);

	initial Clk = 1'b0;
	always #5 Clk = ~Clk; // 10 ns period

endmodule

// File: dv/mipsCoreTb.sv
`timescale 1ns/10ps

module mipsCoreTb;

	localparam int TimeoutCycles = 500;
	localparam logic [31:0] LfsrSeed = 32'h6ba8;
	localparam logic [15:0] StoreBase = 16'h0100;

	logic Clk;
	logic rstN;
	logic [31:0] imemData, dmemRdData, imemAddr, dmemAddr, dmemWrData;
	logic dmemWrEn;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] lfsr;
	int progIdx;
	logic [15:0] storeAddr;
	logic [31:0] expAddr[$], expData[$], gotAddr[$], gotData[$];

	tbClock clkGen (.Clk);

	mipsCore DUT (.Clk, .rstN, .imemData, .dmemRdData, .imemAddr, .dmemAddr, .dmemWrData,
		.dmemWrEn);

	always @(negedge Clk) begin
		imemData <= imem[imemAddr[9:2]];
		dmemRdData <= dmem[dmemAddr[9:2]];
	end

	always @(posedge Clk) begin
		if (rstN && dmemWrEn) begin
			dmem[dmemAddr[9:2]] <= dmemWrData;
			gotAddr.push_back(dmemAddr);
			gotData.push_back(dmemWrData);
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic [31:0] fillWord(input int index);
		return 32'hd0d0_0000 + 32'(index);
	endfunction

	function automatic logic [31:0] encR(input logic [5:0] funct, input int rs, input int rt,
		input int rd, input int sh);
		return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] encJ(input logic [31:0] target);
		return {6'(mipsPkg::opJ), target[27:2]};
	endfunction

	task automatic failNow(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic emit(input logic [31:0] word);
		imem[progIdx] = word;
		progIdx++;
	endtask

	task automatic loadWord(input int rd, input logic [31:0] value);
		emit(encI(mipsPkg::opLui, 0, rd, value[31:16]));
		emit(encI(mipsPkg::opOri, rd, rd, value[15:0]));
	endtask

	// Every store gets its own address so squashed slots are visible
	task automatic emitStore(input int rt, input logic [31:0] value, input bit expected);
		emit(encI(mipsPkg::opSw, 0, rt, storeAddr));
		if (expected) begin
			expAddr.push_back({16'h0000, storeAddr});
			expData.push_back(value);
		end
		storeAddr += 16'd4;
	endtask

	task automatic startProgram();
		@(negedge Clk);
		rstN = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = fillWord(i);
		end
		progIdx = 0;
		storeAddr = StoreBase;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic runProgram();
		int cycles;
		emit(encJ(32'(progIdx) << 2)); // Park in a self loop
		for (int i = 0; i < 8; i++) begin
			@(negedge Clk);
			assert (imemAddr == 32'h0) else
				failNow($sformatf("MISMATCH imemAddr in reset: got %h expected %h", imemAddr, 32'h0));
			assert (dmemWrEn == 1'b0) else
				failNow($sformatf("MISMATCH dmemWrEn in reset: got %h expected %h", dmemWrEn, 1'b0));
		end
		gotAddr.delete();
		gotData.delete();
		rstN = 1'b1;
		cycles = 0;
		while (gotAddr.size() < expAddr.size()) begin
			@(negedge Clk);
			cycles++;
			if (cycles > TimeoutCycles)
				failNow($sformatf("Timed out with %0d of %0d stores seen", gotAddr.size(),
					expAddr.size()));
		end
		for (int i = 0; i < expAddr.size(); i++) begin
			assert (gotAddr[i] == expAddr[i]) else
				failNow($sformatf("MISMATCH dmemAddr store %0d: got %h expected %h", i,
					gotAddr[i], expAddr[i]));
			assert (gotData[i] == expData[i]) else
				failNow($sformatf("MISMATCH dmemWrData store %0d: got %h expected %h", i,
					gotData[i], expData[i]));
		end
	endtask

	task automatic aluR(input logic [5:0] funct, input logic [31:0] value);
		emit(encR(funct, 1, 2, 3, 0));
		emitStore(3, value, 1'b1);
	endtask

	task automatic aluI(input logic [5:0] op, input logic [15:0] imm, input logic [31:0] value);
		emit(encI(op, 1, 3, imm));
		emitStore(3, value, 1'b1);
	endtask

	task automatic testAlu();
		logic [31:0] a, b, immS, immZ;
		logic [15:0] imm;
		logic [4:0] sh;
		startProgram();
		a = randBits(32);
		b = randBits(32);
		imm = randBits(16);
		sh = randBits(5);
		immS = {{16{imm[15]}}, imm};
		immZ = {16'h0000, imm};
		loadWord(1, a);
		loadWord(2, b);
		aluR(mipsPkg::fnAdd, a + b);
		aluR(mipsPkg::fnAddu, a + b);
		aluR(mipsPkg::fnSub, a - b);
		aluR(mipsPkg::fnSubu, a - b);
		aluR(mipsPkg::fnAndOp, a & b);
		aluR(mipsPkg::fnOrOp, a | b);
		aluR(mipsPkg::fnXorOp, a ^ b);
		aluR(mipsPkg::fnNorOp, ~(a | b));
		aluR(mipsPkg::fnSlt, {31'd0, $signed(a) < $signed(b)});
		aluR(mipsPkg::fnSltu, {31'd0, a < b});
		emit(encR(mipsPkg::fnSll, 0, 1, 3, sh)); // Shifts rt
		emitStore(3, a << sh, 1'b1);
		aluI(mipsPkg::opAddi, imm, a + immS);
		aluI(mipsPkg::opAddiu, imm, a + immS);
		aluI(mipsPkg::opSlti, imm, {31'd0, $signed(a) < $signed(immS)});
		aluI(mipsPkg::opSltiu, imm, {31'd0, a < immS});
		aluI(mipsPkg::opAndi, imm, a & immZ);
		aluI(mipsPkg::opOri, imm, a | immZ);
		aluI(mipsPkg::opXori, imm, a ^ immZ);
		aluI(mipsPkg::opLui, imm, {imm, 16'h0000});
		runProgram();
	endtask

	task automatic testForwarding();
		logic [31:0] a, v5, v6, v7, v8, v9;
		startProgram();
		a = randBits(32);
		v5 = a + a;
		v6 = v5 - a;
		v7 = v6 ^ a;
		v8 = v7 + v5;
		v9 = ~(v8 | v6);
		loadWord(4, a);
		emit(encR(mipsPkg::fnAddu, 4, 4, 5, 0));
		emit(encR(mipsPkg::fnSubu, 5, 4, 6, 0)); // r4 two back
		emit(encR(mipsPkg::fnXorOp, 6, 4, 7, 0)); // r4 three back
		emit(encR(mipsPkg::fnAddu, 7, 5, 8, 0));
		emit(encR(mipsPkg::fnNorOp, 8, 6, 9, 0));
		emitStore(9, v9, 1'b1);
		emitStore(8, v8, 1'b1);
		emitStore(7, v7, 1'b1);
		emitStore(6, v6, 1'b1);
		emitStore(5, v5, 1'b1);
		runProgram();
	endtask

	task automatic testMemory();
		logic [31:0] x, y;
		startProgram();
		x = randBits(32);
		y = randBits(32);
		loadWord(10, x);
		loadWord(11, y);
		emitStore(10, x, 1'b1);
		emitStore(11, y, 1'b1);
		emit(encI(mipsPkg::opLw, 0, 12, StoreBase));
		emit(encI(mipsPkg::opLw, 0, 13, StoreBase + 16'd4));
		emit(encR(mipsPkg::fnAddu, 12, 13, 14, 0)); // Load result used at once
		emitStore(14, x + y, 1'b1);
		emitStore(12, x, 1'b1);
		emitStore(13, y, 1'b1);
		emit(encI(mipsPkg::opAddiu, 10, 0, 16'h0005));
		emitStore(0, 32'h0, 1'b1);
		emit(encI(mipsPkg::opLw, 0, 0, StoreBase));
		emitStore(0, 32'h0, 1'b1);
		emit(encI(mipsPkg::opLw, 0, 15, 16'h0300)); // Never written
		emitStore(15, fillWord(32'h300 >> 2), 1'b1);
		runProgram();
	endtask

	task automatic branchBlock(input logic [5:0] op, input int rs, input int rt,
		input bit taken, input logic [31:0] value);
		emit(encI(op, rs, rt, 16'd2));
		emitStore(20, value, !taken);
		emitStore(20, value, !taken);
		emitStore(20, value, 1'b1); // Branch target
	endtask

	task automatic testBranches();
		logic [31:0] c, d;
		startProgram();
		c = randBits(32);
		d = c ^ (randBits(31) | 32'h1);
		loadWord(20, c);
		loadWord(21, c);
		loadWord(22, d);
		branchBlock(mipsPkg::opBeq, 20, 21, 1'b1, c);
		branchBlock(mipsPkg::opBeq, 20, 22, 1'b0, c);
		branchBlock(mipsPkg::opBne, 20, 22, 1'b1, c);
		branchBlock(mipsPkg::opBne, 20, 21, 1'b0, c);
		runProgram();
	endtask

	task automatic testJump();
		logic [31:0] e;
		startProgram();
		e = randBits(32);
		loadWord(23, e);
		emit(encJ(32'(progIdx + 3) << 2));
		emitStore(23, e, 1'b0); // Squashed
		emitStore(23, e, 1'b0); // Never fetched
		emitStore(23, e, 1'b1);
		emitStore(23, e, 1'b1);
		runProgram();
	endtask

	initial begin
		rstN = 1'b0;
		imemData = '0;
		dmemRdData = '0;
		lfsr = LfsrSeed;
		for (int r = 0; r < 3; r++)
			testAlu();
		testForwarding();
		testMemory();
		testBranches();
		testJump();
		$display("All checks passed");
		$finish;
	end

endmodule

// File: mipsCore.f
rtl/mipsPkg.sv
rtl/fetchUnit.sv
rtl/instDecoder.sv
rtl/registerFile.sv
rtl/forwardingUnit.sv
rtl/executeStage.sv
rtl/mipsCore.sv
dv/tbClock.sv
dv/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mipsCore

sources:
  - files:
      - rtl/mipsPkg.sv
      - rtl/fetchUnit.sv
      - rtl/instDecoder.sv
      - rtl/registerFile.sv
      - rtl/forwardingUnit.sv
      - rtl/executeStage.sv
      - rtl/mipsCore.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/mipsCoreTb.sv
